// File: hw/icache_data_array.sv
// icache data array
// cache line storage for every set and way, registered one-cycle read,
// written by the q3 response stage

module icache_data_array
  import icache_pkg::*;
#(
  parameter int NUM_SETS = 16,
  parameter int NUM_WAYS = 4,
  localparam int SET_W = $clog2(NUM_SETS),
  localparam int WAY_W = $clog2(NUM_WAYS)
) (
  input  logic                  clk,
  input  logic [SET_W-1:0]      rd_set,   // q2 read address
  input  logic [WAY_W-1:0]      rd_way,
  output logic [LINE_WIDTH-1:0] rd_line,  // valid in q3
  input  logic                  wr_en,    // q3 fill write
  input  logic [SET_W-1:0]      wr_set,
  input  logic [WAY_W-1:0]      wr_way,
  input  logic [LINE_WIDTH-1:0] wr_line
);

  // one entry per {set, way}
  logic [LINE_WIDTH-1:0] line_mem [NUM_SETS*NUM_WAYS];

  always_ff @(posedge clk) begin
    if (wr_en) line_mem[{wr_set, wr_way}] <= wr_line;
  end

  // read-before-write on a shared edge, q4 copy in the rsp stage covers it
  always_ff @(posedge clk) begin
    rd_line <= line_mem[{rd_set, rd_way}];
  end

endmodule

// File: hw/icache_lookup_top.sv
// icache lookup top
// three-stage set-associative lookup pipe: q1 request, q2 tag compare,
// q3 response. one lookup per cycle, no back-pressure

module icache_lookup_top
  import icache_pkg::*;
#(
  parameter int NUM_SETS = 16,
  parameter int NUM_WAYS = 4,   // power of two
  localparam int SET_W = $clog2(NUM_SETS),
  localparam int WAY_W = $clog2(NUM_WAYS),
  localparam int TAG_W = ADDR_WIDTH - OFFSET_WIDTH - SET_W
) (
  input  logic                    clk,
  input  logic                    rst,
  // lookup request
  input  logic                    lu_valid,
  input  lu_op_e                  lu_op,
  input  logic [ADDR_WIDTH-1:0]   lu_addr,
  input  logic [ID_WIDTH-1:0]     lu_id,
  input  logic [LINE_WIDTH-1:0]   lu_line,   // fill data
  input  logic                    lu_cancel, // line already being fetched
  // lookup response
  output logic                    rsp_valid,
  output lu_op_e                  rsp_op,
  output lu_result_e              rsp_result,
  output logic [ID_WIDTH-1:0]     rsp_id,
  output logic [ADDR_WIDTH-1:0]   rsp_addr,
  output logic [LINE_WIDTH-1:0]   rsp_line,
  // fill memory request
  output logic                    fm_req_valid,
  output fm_op_e                  fm_req_op,
  output logic [ADDR_WIDTH-1:0]   fm_req_addr,
  output logic [ID_WIDTH-1:0]     fm_req_id
);

  //======================================================================
  // stage to stage wires
  //======================================================================
  logic [SET_W-1:0]                 rd_set;
  logic [NUM_WAYS-1:0][TAG_W-1:0]   rd_tags;
  logic [NUM_WAYS-1:0]              rd_valid, rd_mru;
  logic                             set_wr_en;
  logic [SET_W-1:0]                 set_wr_set;
  logic [NUM_WAYS-1:0][TAG_W-1:0]   set_wr_tags;
  logic [NUM_WAYS-1:0]              set_wr_valid, set_wr_mru;
  logic [SET_W-1:0]                 cl_rd_set, cl_wr_set;
  logic [WAY_W-1:0]                 cl_rd_way, cl_wr_way;
  logic                             cl_wr_en;
  logic [LINE_WIDTH-1:0]            cl_rd_line, cl_wr_line;

  logic                             q2_valid, q2_cancel, q3_valid, q3_cancel, q3_hit;
  lu_op_e                           q2_op, q3_op;
  logic [TAG_W-1:0]                 q2_tag, q3_tag;
  logic [SET_W-1:0]                 q2_set, q3_set;
  logic [OFFSET_WIDTH-1:0]          q2_offset, q3_offset;
  logic [ID_WIDTH-1:0]              q2_id, q3_id;
  logic [LINE_WIDTH-1:0]            q2_line, q3_line;
  logic [WAY_W-1:0]                 q3_way;

  // q1: address split and tag read
  icache_req_stage #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) u_req_stage (.*);

  icache_tag_array #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) u_tag_array (
    .clk, .rst, .rd_set, .rd_tags, .rd_valid, .rd_mru,
    .wr_en(set_wr_en), .wr_set(set_wr_set), .wr_tags(set_wr_tags),
    .wr_valid(set_wr_valid), .wr_mru(set_wr_mru)
  );

  // q2: compare, victim, set update
  icache_tag_stage #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) u_tag_stage (
    .clk, .rst,
    .q2_valid, .q2_op, .q2_tag, .q2_set, .q2_offset, .q2_id, .q2_line, .q2_cancel,
    .rd_tags, .rd_valid, .rd_mru,
    .wr_en(set_wr_en), .wr_set(set_wr_set), .wr_tags(set_wr_tags),
    .wr_valid(set_wr_valid), .wr_mru(set_wr_mru),
    .cl_rd_set, .cl_rd_way,
    .q3_valid, .q3_op, .q3_tag, .q3_set, .q3_offset, .q3_id, .q3_line, .q3_cancel,
    .q3_hit, .q3_way
  );

  icache_data_array #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) u_data_array (
    .clk, .rd_set(cl_rd_set), .rd_way(cl_rd_way), .rd_line(cl_rd_line),
    .wr_en(cl_wr_en), .wr_set(cl_wr_set), .wr_way(cl_wr_way), .wr_line(cl_wr_line)
  );

  // q3: response, miss request, line write
  icache_rsp_stage #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) u_rsp_stage (
    .clk, .rst,
    .q3_valid, .q3_op, .q3_tag, .q3_set, .q3_offset, .q3_id, .q3_line, .q3_cancel,
    .q3_hit, .q3_way, .rd_line(cl_rd_line),
    .wr_en(cl_wr_en), .wr_set(cl_wr_set), .wr_way(cl_wr_way), .wr_line(cl_wr_line),
    .rsp_valid, .rsp_op, .rsp_result, .rsp_id, .rsp_addr, .rsp_line,
    .fm_req_valid, .fm_req_op, .fm_req_addr, .fm_req_id
  );

endmodule

// File: hw/icache_pkg.sv
// icache lookup package
// shared widths and encodings for the three-stage instruction cache lookup pipe

package icache_pkg;

  //======================================================================
  // address and line geometry
  //======================================================================
  parameter int ADDR_WIDTH     = 20;                          // byte address
  parameter int WORD_WIDTH     = 32;
  parameter int WORDS_PER_LINE = 4;
  parameter int LINE_WIDTH     = WORD_WIDTH * WORDS_PER_LINE; // 128 bit cache line
  parameter int OFFSET_WIDTH   = 4;                           // byte offset in a line
  parameter int ID_WIDTH       = 4;                           // requester transaction id

  //======================================================================
  // opcodes and results
  //======================================================================
  // lookup opcode on the request side
  typedef enum logic [0:0] {
    RD_LU   = 1'b0,   // read lookup
    FILL_LU = 1'b1    // line fill into a victim way
  } lu_op_e;

  // q3 response result
  typedef enum logic [1:0] {
    NO_RSP = 2'b00,
    HIT    = 2'b01,
    MISS   = 2'b10,
    FILL   = 2'b11
  } lu_result_e;

  // outward fill memory request, only the fill request exists
  typedef enum logic [0:0] {
    FILL_REQ_OP = 1'b0
  } fm_op_e;

endpackage

// File: hw/icache_req_stage.sv
// icache request stage (q1)
// splits the lookup address, issues the tag array read and registers
// the lookup into q2

module icache_req_stage
  import icache_pkg::*;
#(
  parameter int NUM_SETS = 16,
  parameter int NUM_WAYS = 4,
  localparam int SET_W = $clog2(NUM_SETS),
  localparam int TAG_W = ADDR_WIDTH - OFFSET_WIDTH - SET_W
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    lu_valid,
  input  lu_op_e                  lu_op,
  input  logic [ADDR_WIDTH-1:0]   lu_addr,
  input  logic [ID_WIDTH-1:0]     lu_id,
  input  logic [LINE_WIDTH-1:0]   lu_line,
  input  logic                    lu_cancel,
  output logic [SET_W-1:0]        rd_set,     // tag array read in q1
  output logic                    q2_valid,
  output lu_op_e                  q2_op,
  output logic [TAG_W-1:0]        q2_tag,
  output logic [SET_W-1:0]        q2_set,
  output logic [OFFSET_WIDTH-1:0] q2_offset,
  output logic [ID_WIDTH-1:0]     q2_id,
  output logic [LINE_WIDTH-1:0]   q2_line,
  output logic                    q2_cancel
);

  // address layout is {tag, set, offset}
  assign rd_set = lu_addr[OFFSET_WIDTH +: SET_W];

  always_ff @(posedge clk) begin
    if (rst) q2_valid <= 1'b0;
    else     q2_valid <= lu_valid;
  end

  // payload follows the valid flag
  always_ff @(posedge clk) begin
    q2_op     <= lu_op;
    q2_tag    <= lu_addr[ADDR_WIDTH-1 -: TAG_W];
    q2_set    <= rd_set;
    q2_offset <= lu_addr[OFFSET_WIDTH-1:0];
    q2_id     <= lu_id;
    q2_line   <= lu_line;
    q2_cancel <= lu_cancel;
  end

endmodule

// File: hw/icache_rsp_stage.sv
// icache response stage (q3)
// line forwarding from q4, lookup response, outward fill request on an
// uncancelled read miss, and the data array write for fills

module icache_rsp_stage
  import icache_pkg::*;
#(
  parameter int NUM_SETS = 16,
  parameter int NUM_WAYS = 4,
  localparam int SET_W = $clog2(NUM_SETS),
  localparam int WAY_W = $clog2(NUM_WAYS),
  localparam int TAG_W = ADDR_WIDTH - OFFSET_WIDTH - SET_W
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    q3_valid,
  input  lu_op_e                  q3_op,
  input  logic [TAG_W-1:0]        q3_tag,
  input  logic [SET_W-1:0]        q3_set,
  input  logic [OFFSET_WIDTH-1:0] q3_offset,
  input  logic [ID_WIDTH-1:0]     q3_id,
  input  logic [LINE_WIDTH-1:0]   q3_line,
  input  logic                    q3_cancel,
  input  logic                    q3_hit,
  input  logic [WAY_W-1:0]        q3_way,
  input  logic [LINE_WIDTH-1:0]   rd_line,
  output logic                    wr_en,
  output logic [SET_W-1:0]        wr_set,
  output logic [WAY_W-1:0]        wr_way,
  output logic [LINE_WIDTH-1:0]   wr_line,
  output logic                    rsp_valid,
  output lu_op_e                  rsp_op,
  output lu_result_e              rsp_result,
  output logic [ID_WIDTH-1:0]     rsp_id,
  output logic [ADDR_WIDTH-1:0]   rsp_addr,
  output logic [LINE_WIDTH-1:0]   rsp_line,
  output logic                    fm_req_valid,
  output fm_op_e                  fm_req_op,
  output logic [ADDR_WIDTH-1:0]   fm_req_addr,
  output logic [ID_WIDTH-1:0]     fm_req_id
);

  logic                  q4_valid;       // a fill was written last cycle
  logic [SET_W-1:0]      q4_set;
  logic [WAY_W-1:0]      q4_way;
  logic [LINE_WIDTH-1:0] q4_line, cur_line;
  logic                  is_fill;

  //======================================================================
  // line forwarding, array read missed last cycle's fill write
  //======================================================================
  assign cur_line = (q4_valid && q4_set == q3_set && q4_way == q3_way) ? q4_line : rd_line;
  assign is_fill  = (q3_op == FILL_LU);

  //======================================================================
  // response and miss request
  //======================================================================
  assign rsp_valid  = q3_valid;
  assign rsp_op     = q3_op;
  assign rsp_id     = q3_id;
  assign rsp_addr   = {q3_tag, q3_set, q3_offset};
  assign rsp_result = !q3_valid ? NO_RSP :
                      is_fill   ? FILL   :
                      q3_hit    ? HIT    : MISS;
  assign rsp_line   = is_fill ? q3_line  :
                      q3_hit  ? cur_line : '0;   // zero on a miss

  assign fm_req_valid = q3_valid && !is_fill && !q3_hit && !q3_cancel;
  assign fm_req_op    = FILL_REQ_OP;
  assign fm_req_addr  = rsp_addr;
  assign fm_req_id    = q3_id;

  // fill write lands at the end of q3
  assign wr_en   = q3_valid && is_fill;
  assign wr_set  = q3_set;
  assign wr_way  = q3_way;
  assign wr_line = q3_line;

  always_ff @(posedge clk) begin
    if (rst) q4_valid <= 1'b0;
    else     q4_valid <= wr_en;
  end

  always_ff @(posedge clk) begin
    q4_set  <= wr_set;
    q4_way  <= wr_way;
    q4_line <= wr_line;
  end

endmodule

// File: hw/icache_tag_array.sv
// icache tag array
// per-set tags, valid and MRU bits for all ways, registered one-cycle read,
// whole-set write from the q2 tag stage

module icache_tag_array
  import icache_pkg::*;
#(
  parameter int NUM_SETS = 16,
  parameter int NUM_WAYS = 4,
  localparam int SET_W = $clog2(NUM_SETS),
  localparam int TAG_W = ADDR_WIDTH - OFFSET_WIDTH - SET_W
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [SET_W-1:0]               rd_set,    // q1 read index
  output logic [NUM_WAYS-1:0][TAG_W-1:0] rd_tags,   // valid in q2
  output logic [NUM_WAYS-1:0]            rd_valid,
  output logic [NUM_WAYS-1:0]            rd_mru,
  input  logic                           wr_en,     // q2 set write-back
  input  logic [SET_W-1:0]               wr_set,
  input  logic [NUM_WAYS-1:0][TAG_W-1:0] wr_tags,
  input  logic [NUM_WAYS-1:0]            wr_valid,
  input  logic [NUM_WAYS-1:0]            wr_mru
);

  logic [NUM_WAYS-1:0][TAG_W-1:0] tag_mem [NUM_SETS];
  logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;  // control state, cleared on reset
  logic [NUM_SETS-1:0][NUM_WAYS-1:0] mru_q;

  // tags themselves are don't-care until valid
  always_ff @(posedge clk) begin
    if (wr_en) tag_mem[wr_set] <= wr_tags;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      mru_q   <= '0;
    end else if (wr_en) begin
      valid_q[wr_set] <= wr_valid;
      mru_q[wr_set]   <= wr_mru;
    end
  end

  // read sees old contents when it hits the same edge as a write
  // the tag stage forwards from q3 for that case
  always_ff @(posedge clk) begin
    rd_tags  <= tag_mem[rd_set];
    rd_valid <= valid_q[rd_set];
    rd_mru   <= mru_q[rd_set];
  end

endmodule

// File: hw/icache_tag_stage.sv
// icache tag stage (q2)
// set forwarding from q3, tag compare, fill victim choice and bit-flip
// pseudo-LRU update, set write-back, data array read and q2 to q3 register

module icache_tag_stage
  import icache_pkg::*;
#(
  parameter int NUM_SETS = 16,
  parameter int NUM_WAYS = 4,
  localparam int SET_W = $clog2(NUM_SETS),
  localparam int WAY_W = $clog2(NUM_WAYS),
  localparam int TAG_W = ADDR_WIDTH - OFFSET_WIDTH - SET_W
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           q2_valid,
  input  lu_op_e                         q2_op,
  input  logic [TAG_W-1:0]               q2_tag,
  input  logic [SET_W-1:0]               q2_set,
  input  logic [OFFSET_WIDTH-1:0]        q2_offset,
  input  logic [ID_WIDTH-1:0]            q2_id,
  input  logic [LINE_WIDTH-1:0]          q2_line,
  input  logic                           q2_cancel,
  input  logic [NUM_WAYS-1:0][TAG_W-1:0] rd_tags,
  input  logic [NUM_WAYS-1:0]            rd_valid,
  input  logic [NUM_WAYS-1:0]            rd_mru,
  output logic                           wr_en,
  output logic [SET_W-1:0]               wr_set,
  output logic [NUM_WAYS-1:0][TAG_W-1:0] wr_tags,
  output logic [NUM_WAYS-1:0]            wr_valid,
  output logic [NUM_WAYS-1:0]            wr_mru,
  output logic [SET_W-1:0]               cl_rd_set,
  output logic [WAY_W-1:0]               cl_rd_way,
  output logic                           q3_valid,
  output lu_op_e                         q3_op,
  output logic [TAG_W-1:0]               q3_tag,
  output logic [SET_W-1:0]               q3_set,
  output logic [OFFSET_WIDTH-1:0]        q3_offset,
  output logic [ID_WIDTH-1:0]            q3_id,
  output logic [LINE_WIDTH-1:0]          q3_line,
  output logic                           q3_cancel,
  output logic                           q3_hit,   // read hit only
  output logic [WAY_W-1:0]               q3_way    // hit way or fill victim
);

  logic [NUM_WAYS-1:0][TAG_W-1:0] set_tags, fwd_tags;  // fwd_* = set written last cycle
  logic [NUM_WAYS-1:0]            set_valid, set_mru, fwd_valid, fwd_mru;
  logic [NUM_WAYS-1:0]            hit_vec, hit_one, vic_one;
  logic [WAY_W-1:0]               hit_way, free_way, lru_way, vic_way;
  logic                           set_hazard, rd_hit, is_fill;

  //======================================================================
  // set forwarding, q3 wrote this set at the edge our read was taken
  //======================================================================
  assign set_hazard = q3_valid && (q3_set == q2_set);
  assign set_tags   = set_hazard ? fwd_tags  : rd_tags;
  assign set_valid  = set_hazard ? fwd_valid : rd_valid;
  assign set_mru    = set_hazard ? fwd_mru   : rd_mru;

  //======================================================================
  // tag compare and victim choice
  //======================================================================
  assign is_fill = (q2_op == FILL_LU);

  always_comb begin
    hit_way  = '0;
    free_way = '0;
    lru_way  = '0;
    // scan downwards so the lowest way wins
    for (int w = NUM_WAYS-1; w >= 0; w--) begin
      hit_vec[w] = set_valid[w] && (set_tags[w] == q2_tag);
      if (hit_vec[w])    hit_way  = WAY_W'(w);
      if (!set_valid[w]) free_way = WAY_W'(w);
      if (!set_mru[w])   lru_way  = WAY_W'(w);  // flip guarantees one exists
    end
  end

  assign rd_hit  = !is_fill && (|hit_vec);
  assign vic_way = (&set_valid) ? lru_way : free_way;  // free way first
  assign hit_one = NUM_WAYS'(1) << hit_way;
  assign vic_one = NUM_WAYS'(1) << vic_way;

  //======================================================================
  // set update, written back for every valid lookup
  //======================================================================
  always_comb begin
    wr_tags  = set_tags;
    wr_valid = set_valid;
    wr_mru   = set_mru;
    if (rd_hit) wr_mru = set_mru | hit_one;
    if (is_fill) begin
      wr_tags[vic_way] = q2_tag;
      wr_valid         = set_valid | vic_one;
      wr_mru           = set_mru | vic_one;
    end
    if (&wr_mru) wr_mru = rd_hit ? hit_one : vic_one;  // bit flip, keep only newest
  end

  assign wr_en  = q2_valid;
  assign wr_set = q2_set;

  // data array read, the fill address is carried on for the q3 write
  assign cl_rd_set = q2_set;
  assign cl_rd_way = is_fill ? vic_way : hit_way;

  //======================================================================
  // q2 -> q3
  //======================================================================
  always_ff @(posedge clk) begin
    if (rst) q3_valid <= 1'b0;
    else     q3_valid <= q2_valid;
  end

  always_ff @(posedge clk) begin
    q3_op     <= q2_op;
    q3_tag    <= q2_tag;
    q3_set    <= q2_set;
    q3_offset <= q2_offset;
    q3_id     <= q2_id;
    q3_line   <= q2_line;
    q3_cancel <= q2_cancel;
    q3_hit    <= rd_hit;
    q3_way    <= cl_rd_way;
    fwd_tags  <= wr_tags;    // used only when q3_valid
    fwd_valid <= wr_valid;
    fwd_mru   <= wr_mru;
  end

endmodule

// File: icache_lookup.f
hw/icache_pkg.sv
hw/icache_tag_array.sv
hw/icache_req_stage.sv
hw/icache_tag_stage.sv
hw/icache_data_array.sv
hw/icache_rsp_stage.sv
hw/icache_lookup_top.sv
sim/icache_checker.sv
sim/tb_icache_lookup.sv

// File: sim/icache_checker.sv
// icache lookup checker
// reference model of tags, valid, MRU and line data, updated in acceptance
// order; compares every response and outward fill request with the model

module icache_checker
  import icache_pkg::*;
#(
  parameter int NUM_SETS = 16,
  parameter int NUM_WAYS = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  lu_valid,
  input  lu_op_e                lu_op,
  input  logic [ADDR_WIDTH-1:0] lu_addr,
  input  logic [ID_WIDTH-1:0]   lu_id,
  input  logic [LINE_WIDTH-1:0] lu_line,
  input  logic                  lu_cancel,
  input  logic                  rsp_valid,
  input  lu_op_e                rsp_op,
  input  lu_result_e            rsp_result,
  input  logic [ID_WIDTH-1:0]   rsp_id,
  input  logic [ADDR_WIDTH-1:0] rsp_addr,
  input  logic [LINE_WIDTH-1:0] rsp_line,
  input  logic                  fm_req_valid,
  input  fm_op_e                fm_req_op,
  input  logic [ADDR_WIDTH-1:0] fm_req_addr,
  input  logic [ID_WIDTH-1:0]   fm_req_id,
  output int                    checks,
  output int                    errors,
  output int                    pending    // lookups still waiting for a response
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int SET_W = $clog2(NUM_SETS);
  localparam int TAG_W = ADDR_WIDTH - OFFSET_WIDTH - SET_W;

  // one expected response per accepted lookup
  typedef struct packed {
    logic [31:0]           due;     // cycle count at which rsp must show
    lu_op_e                op;
    lu_result_e            result;
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LINE_WIDTH-1:0] line;
    logic                  fm;      // outward fill request expected
  } expect_t;

  expect_t               exp_q[$];
  logic [TAG_W-1:0]      m_tag   [NUM_SETS][NUM_WAYS];
  logic                  m_valid [NUM_SETS][NUM_WAYS];
  logic                  m_mru   [NUM_SETS][NUM_WAYS];
  logic [LINE_WIDTH-1:0] m_line  [NUM_SETS][NUM_WAYS];

  //======================================================================
  // reference model
  //======================================================================
  task automatic clear_model();
    int s, w;
    for (s = 0; s < NUM_SETS; s++)
      for (w = 0; w < NUM_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_mru[s][w]   = 1'b0;
      end
  endtask

  // lowest matching way, -1 when nothing matches
  function automatic int find_way(input int s, input logic [TAG_W-1:0] t);
    int w;
    find_way = -1;
    for (w = 0; w < NUM_WAYS; w++)
      if (find_way < 0 && m_valid[s][w] && m_tag[s][w] == t) find_way = w;
  endfunction

  function automatic int pick_victim(input int s);
    int w;
    pick_victim = -1;
    for (w = 0; w < NUM_WAYS; w++)
      if (pick_victim < 0 && !m_valid[s][w]) pick_victim = w;   // free way first
    for (w = 0; w < NUM_WAYS; w++)
      if (pick_victim < 0 && !m_mru[s][w]) pick_victim = w;     // then first non-MRU
  endfunction

  // mark way as most recent; when all bits end up set only this one survives
  task automatic touch(input int s, input int w);
    int i, ones;
    m_mru[s][w] = 1'b1;
    ones = 0;
    for (i = 0; i < NUM_WAYS; i++) ones += m_mru[s][i];
    if (ones == NUM_WAYS) begin
      for (i = 0; i < NUM_WAYS; i++) m_mru[s][i] = (i == w);
    end
  endtask

  task automatic apply_lookup(input int cyc);
    int s, w;
    logic [TAG_W-1:0] t;
    expect_t e;
    s = lu_addr[OFFSET_WIDTH +: SET_W];
    t = lu_addr[ADDR_WIDTH-1 -: TAG_W];
    e = '0;
    e.due  = cyc + 1;     // seen in the cycle after the next edge
    e.op   = lu_op;
    e.id   = lu_id;
    e.addr = lu_addr;
    if (lu_op == FILL_LU) begin
      w = pick_victim(s);
      m_tag[s][w]   = t;
      m_valid[s][w] = 1'b1;
      m_line[s][w]  = lu_line;
      touch(s, w);
      e.result = FILL;
      e.line   = lu_line;
    end else begin
      w = find_way(s, t);
      if (w >= 0) begin
        touch(s, w);
        e.result = HIT;
        e.line   = m_line[s][w];
      end else begin
        e.result = MISS;     // line stays zero
        e.fm     = !lu_cancel;
      end
    end
    exp_q.push_back(e);
  endtask

  //======================================================================
  // comparison
  //======================================================================
  task automatic compare(input string name, input logic [LINE_WIDTH-1:0] got,
                         input logic [LINE_WIDTH-1:0] exp_v);
    checks++;
    if (got !== exp_v) begin
      errors++;
      $display("error: %0s got %0h expected %0h", name, got, exp_v);
    end
  endtask

  task automatic check_outputs(input int cyc);
    expect_t e;
    if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
      e = exp_q.pop_front();
      if (rsp_valid !== 1'b1) begin
        checks++;
        errors++;
        $display("no response came for lookup id %0h at address %0h", e.id, e.addr);
      end else begin
        compare("rsp_op", rsp_op, e.op);
        compare("rsp_result", rsp_result, e.result);
        compare("rsp_id", rsp_id, e.id);
        compare("rsp_addr", rsp_addr, e.addr);
        compare("rsp_line", rsp_line, e.line);
      end
      compare("fm_req_valid", fm_req_valid, e.fm);
      if (e.fm) begin
        compare("fm_req_op", fm_req_op, FILL_REQ_OP);
        compare("fm_req_addr", fm_req_addr, e.addr);
        compare("fm_req_id", fm_req_id, e.id);
      end
    end else begin
      // nothing due, so the outputs must be quiet
      compare("rsp_valid", rsp_valid, 1'b0);
      compare("fm_req_valid", fm_req_valid, 1'b0);
    end
  endtask

  // inputs taken at the rising edge, outputs judged at the falling edge
  initial begin : watch
    int cyc;
    bit active;
    checks  = 0;
    errors  = 0;
    pending = 0;
    cyc     = 0;
    active  = 1'b0;
    forever begin
      @(posedge clk);
      cyc++;
      active = !rst;
      if (rst) begin
        clear_model();
        exp_q.delete();
      end else if (lu_valid) begin
        apply_lookup(cyc);
      end
      pending = exp_q.size();
      @(negedge clk);
      if (active) check_outputs(cyc);
      pending = exp_q.size();
    end
  end

endmodule

// File: sim/tb_icache_lookup.sv
// icache lookup testbench
// clock, reset, directed and seeded random lookups into the pipe;
// the attached checker model judges every response

module tb_icache_lookup
  import icache_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_SETS     = 16;
  localparam int NUM_WAYS     = 4;
  localparam int SET_W        = $clog2(NUM_SETS);
  localparam int TAG_W        = ADDR_WIDTH - OFFSET_WIDTH - SET_W;
  localparam int LINE_A_W     = ADDR_WIDTH - OFFSET_WIDTH;   // line address bits
  localparam int DRAIN_LIMIT  = 40;     // cycles allowed to empty the pipe
  localparam int RAND_LOOKUPS = 2000;

  logic                  clk, rst;
  logic                  lu_valid, lu_cancel;
  lu_op_e                lu_op;
  logic [ADDR_WIDTH-1:0] lu_addr;
  logic [ID_WIDTH-1:0]   lu_id;
  logic [LINE_WIDTH-1:0] lu_line;
  logic                  rsp_valid, fm_req_valid;
  lu_op_e                rsp_op;
  lu_result_e            rsp_result;
  logic [ID_WIDTH-1:0]   rsp_id, fm_req_id;
  logic [ADDR_WIDTH-1:0] rsp_addr, fm_req_addr;
  logic [LINE_WIDTH-1:0] rsp_line;
  fm_op_e                fm_req_op;

  int                    checks, errors, pending;
  int                    tests, base_checks, base_errors;
  int                    timeouts;               // tests whose pipe never drained
  logic [ID_WIDTH-1:0]   next_id;
  bit                    owed [1 << LINE_A_W];   // a fill is still owed for this line

  icache_lookup_top #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) uut (.*);
  icache_checker    #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) chk (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns period
  end

  //======================================================================
  // stimulus helpers
  //======================================================================
  function automatic logic [ADDR_WIDTH-1:0] make_addr(input int tag, input int set,
                                                      input int off);
    return {TAG_W'(tag), SET_W'(set), OFFSET_WIDTH'(off)};
  endfunction

  // fill data is a fixed function of the line address with each word different
  function automatic logic [LINE_WIDTH-1:0] fill_line(input logic [ADDR_WIDTH-1:0] addr);
    logic [LINE_A_W-1:0]   la;
    logic [LINE_WIDTH-1:0] l;
    int                    i;
    la = addr[ADDR_WIDTH-1:OFFSET_WIDTH];
    for (i = 0; i < WORDS_PER_LINE; i++)
      l[i*WORD_WIDTH +: WORD_WIDTH] = {la, 8'(i), 8'hc5} ^ (32'h9e37_79b9 * (la + 1));
    return l;
  endfunction

  task automatic send(input lu_op_e op, input logic [ADDR_WIDTH-1:0] addr);
    logic [LINE_A_W-1:0] la;
    la = addr[ADDR_WIDTH-1:OFFSET_WIDTH];
    @(negedge clk);
    lu_valid = 1'b1;
    lu_op    = op;
    lu_addr  = addr;
    lu_id    = next_id;
    next_id++;
    if (op == FILL_LU) begin
      lu_line   = fill_line(addr);
      lu_cancel = 1'b0;
      owed[la]  = 1'b0;    // fill delivered
    end else begin
      lu_line   = {$urandom, $urandom, $urandom, $urandom};   // don't care on reads
      lu_cancel = owed[la];                                   // already being fetched
      owed[la]  = 1'b1;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      lu_valid = 1'b0;
    end
  endtask

  // let the pipe drain, then report this test's counts
  task automatic end_test(input string name);
    int waited;
    waited = 0;
    idle(1);
    while (pending != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    tests++;
    if (pending != 0) begin
      timeouts++;
      $display("test %0d %0s: timeout, %0d responses never arrived", tests, name, pending);
    end else begin
      $display("test %0d %0s: %0d checks, %0d errors", tests, name,
               checks - base_checks, errors - base_errors);
    end
    base_checks = checks;
    base_errors = errors;
  endtask

  //======================================================================
  // test sequence
  //======================================================================
  initial begin : main
    int k, s, t, off;
    lu_op_e op;
    void'($urandom(32'h4915_c63b));
    rst       = 1'b1;
    lu_valid  = 1'b0;
    lu_op     = RD_LU;
    lu_addr   = '0;
    lu_id     = '0;
    lu_line   = '0;
    lu_cancel = 1'b0;
    next_id   = '0;
    tests       = 0;
    base_checks = 0;
    base_errors = 0;
    timeouts    = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // quiet outputs, then cold misses
    idle(4);
    send(RD_LU, make_addr(1, 0, 0));
    send(RD_LU, make_addr(2, 1, 4));
    send(RD_LU, make_addr(3, 2, 8));
    send(RD_LU, make_addr(1, 3, 12));
    end_test("reset");

    // second read of the same line is cancelled
    send(RD_LU, make_addr(9, 4, 0));
    send(RD_LU, make_addr(9, 4, 4));
    send(RD_LU, make_addr(10, 4, 3));
    idle(2);
    send(RD_LU, make_addr(10, 4, 3));
    end_test("miss request");

    send(FILL_LU, make_addr(9, 4, 0));
    idle(3);
    send(RD_LU, make_addr(9, 4, 8));
    end_test("fill then read");

    // back to back in the same set
    send(FILL_LU, make_addr(2, 6, 0));
    send(RD_LU, make_addr(2, 6, 4));
    send(FILL_LU, make_addr(3, 6, 0));
    send(FILL_LU, make_addr(4, 6, 0));
    idle(2);
    send(RD_LU, make_addr(3, 6, 0));
    send(RD_LU, make_addr(4, 6, 0));
    send(RD_LU, make_addr(2, 6, 0));
    end_test("back-to-back hazards");

    // six tags through one four-way set
    for (k = 1; k <= 4; k++) send(FILL_LU, make_addr(k, 9, 0));
    send(RD_LU, make_addr(1, 9, 0));
    send(FILL_LU, make_addr(5, 9, 0));
    for (k = 1; k <= 5; k++) send(RD_LU, make_addr(k, 9, 0));
    send(FILL_LU, make_addr(6, 9, 0));
    idle(1);
    for (k = 1; k <= 6; k++) send(RD_LU, make_addr(k, 9, 4));
    end_test("replacement");

    // small pool of three sets with six tags each
    for (k = 0; k < RAND_LOOKUPS; k++) begin
      if ($urandom % 8 == 0) idle(1);
      s   = 3 + 4 * ($urandom % 3);
      t   = $urandom % 6;
      off = $urandom % 16;
      op  = ($urandom % 10 < 3) ? FILL_LU : RD_LU;
      send(op, make_addr(t, s, off));
    end
    end_test("random mix");

    $display("summary: %0d tests, %0d checks, %0d errors, %0d timeouts",
             tests, checks, errors, timeouts);
    if (errors == 0 && timeouts == 0 && checks > 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule
